/* source/lsb_pkg.sv */
package lsb_pkg;

  localparam int xlen      = 32;
  localparam int rob_id_w  = 4;
  localparam int lsb_depth = 8;
  localparam int lsb_idx_w = 3;
  localparam int imm_w     = 12;

  typedef logic [xlen-1:0] word_t;
  // id 0 means no dependency
  typedef logic [rob_id_w-1:0] rob_id_t;

  // loads first so a store is op >= sb
  typedef enum logic [2:0] {
    lb, lh, lw, lbu, lhu, sb, sh, sw
  } ls_op_e;

  typedef enum logic [1:0] {
    idle, wait_read, wait_write
  } seq_state_e;

  typedef struct packed {
    ls_op_e             op;
    rob_id_t            rob_id;
    rob_id_t            qj;
    rob_id_t            qk;
    word_t              vj;
    word_t              vk;
    logic [imm_w-1:0]   imm;
  } issue_t;

  typedef struct packed {
    logic    valid;
    rob_id_t rob_id;
    word_t   value;
  } cdb_t;

  typedef struct packed {
    ls_op_e  op;
    rob_id_t rob_id;
    word_t   addr;
    word_t   data;
  } head_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

  typedef cdb_t load_result_t;

endpackage

/* source/lsb_entry_queue.sv */
module lsb_entry_queue (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue_valid,
  input  lsb_pkg::issue_t  issue,
  input  lsb_pkg::cdb_t    cdb,
  input  logic             commit_valid,
  input  lsb_pkg::rob_id_t commit_id,
  input  logic             head_pop,
  output lsb_pkg::head_t   head,
  output logic             head_ready,
  output logic             full
);

  typedef logic [lsb_pkg::lsb_idx_w-1:0] idx_t;

  // vj holds the base, then the formed address
  lsb_pkg::issue_t ent [lsb_pkg::lsb_depth];

  logic [lsb_pkg::lsb_depth-1:0] busy;
  logic [lsb_pkg::lsb_depth-1:0] addr_done;
  logic [lsb_pkg::lsb_depth-1:0] committed;
  logic [lsb_pkg::lsb_depth-1:0] commit_hit;

  idx_t                      head_idx;
  idx_t                      tail_idx;
  logic [lsb_pkg::lsb_idx_w:0] count;

  lsb_pkg::issue_t new_ent;
  logic            calc_valid;
  idx_t            calc_idx;
  logic            head_is_store;

  // issue with same-cycle bus forwarding
  always_comb begin
    new_ent = issue;
    if (cdb.valid && issue.qj != '0 && issue.qj == cdb.rob_id) begin
      new_ent.qj = '0;
      new_ent.vj = cdb.value;
    end
    if (cdb.valid && issue.qk != '0 && issue.qk == cdb.rob_id) begin
      new_ent.qk = '0;
      new_ent.vk = cdb.value;
    end
  end

  // lowest index with base ready and no address yet
  always_comb begin
    calc_valid = 1'b0;
    calc_idx   = '0;
    for (int i = lsb_pkg::lsb_depth - 1; i >= 0; i--) begin
      if (busy[i] && ent[i].qj == '0 && !addr_done[i]) begin
        calc_valid = 1'b1;
        calc_idx   = idx_t'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < lsb_pkg::lsb_depth; i++) begin
      commit_hit[i] = commit_valid && busy[i] && ent[i].rob_id == commit_id;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < lsb_pkg::lsb_depth; i++) begin
      if (cdb.valid && busy[i] && ent[i].qj != '0 && ent[i].qj == cdb.rob_id) begin
        ent[i].qj <= '0;
        ent[i].vj <= cdb.value;
      end
      if (cdb.valid && busy[i] && ent[i].qk != '0 && ent[i].qk == cdb.rob_id) begin
        ent[i].qk <= '0;
        ent[i].vk <= cdb.value;
      end
    end
    if (calc_valid) begin
      ent[calc_idx].vj <= ent[calc_idx].vj
                        + {{(lsb_pkg::xlen - lsb_pkg::imm_w){ent[calc_idx].imm[lsb_pkg::imm_w-1]}},
                           ent[calc_idx].imm};
    end
    if (issue_valid) begin
      ent[tail_idx] <= new_ent;
    end
  end

  // control state and pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= '0;
      addr_done <= '0;
      committed <= '0;
      head_idx  <= '0;
      tail_idx  <= '0;
      count     <= '0;
    end else begin
      if (calc_valid) begin
        addr_done[calc_idx] <= 1'b1;
      end
      for (int i = 0; i < lsb_pkg::lsb_depth; i++) begin
        if (commit_hit[i]) begin
          committed[i] <= 1'b1;
        end
      end
      if (issue_valid) begin
        busy[tail_idx]      <= 1'b1;
        addr_done[tail_idx] <= 1'b0;
        committed[tail_idx] <= 1'b0;
        tail_idx            <= tail_idx + 1'b1;
      end
      if (head_pop) begin
        busy[head_idx] <= 1'b0;
        head_idx       <= head_idx + 1'b1;
      end
      case ({issue_valid, head_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign head_is_store = ent[head_idx].op >= lsb_pkg::sb;

  assign head_ready = busy[head_idx]
                   && ent[head_idx].qj == '0
                   && ent[head_idx].qk == '0
                   && addr_done[head_idx]
                   && (!head_is_store || committed[head_idx]);

  assign head.op     = ent[head_idx].op;
  assign head.rob_id = ent[head_idx].rob_id;
  assign head.addr   = ent[head_idx].vj;
  assign head.data   = ent[head_idx].vk;

  // one slot of margin for the issuer
  assign full = count >= lsb_pkg::lsb_depth - 1;

  a_no_issue_when_full: assert property (
    @(posedge clk) disable iff (rst) issue_valid |-> count != lsb_pkg::lsb_depth
  );

  a_pop_needs_ready: assert property (
    @(posedge clk) disable iff (rst) head_pop |-> head_ready
  );

  a_commit_hits_entry: assert property (
    @(posedge clk) disable iff (rst) commit_valid |-> |commit_hit
  );

endmodule

/* source/lsb_mem_sequencer.sv */
module lsb_mem_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  lsb_pkg::head_t        head,
  input  logic                  head_ready,
  input  lsb_pkg::mem_rsp_t     mem_rsp,
  output logic                  head_pop,
  output lsb_pkg::mem_req_t     mem_req,
  output lsb_pkg::load_result_t load_result
);

  lsb_pkg::seq_state_e state;

  logic          is_store;
  logic [4:0]    lane_shift;
  logic [3:0]    wstrb;
  lsb_pkg::word_t rdata_shift;
  lsb_pkg::word_t load_value;
  logic          misaligned;

  assign is_store   = head.op >= lsb_pkg::sb;
  assign lane_shift = {head.addr[1:0], 3'b000};

  always_comb begin
    case (head.op)
      lsb_pkg::sb: wstrb = 4'b0001 << head.addr[1:0];
      lsb_pkg::sh: wstrb = 4'b0011 << head.addr[1:0];
      default:     wstrb = 4'b1111;
    endcase
  end

  // pick the addressed lane, then extend
  assign rdata_shift = mem_rsp.rdata >> lane_shift;

  always_comb begin
    case (head.op)
      lsb_pkg::lb:  load_value = {{(lsb_pkg::xlen - 8){rdata_shift[7]}}, rdata_shift[7:0]};
      lsb_pkg::lh:  load_value = {{(lsb_pkg::xlen - 16){rdata_shift[15]}}, rdata_shift[15:0]};
      lsb_pkg::lbu: load_value = {{(lsb_pkg::xlen - 8){1'b0}}, rdata_shift[7:0]};
      lsb_pkg::lhu: load_value = {{(lsb_pkg::xlen - 16){1'b0}}, rdata_shift[15:0]};
      default:      load_value = rdata_shift;
    endcase
  end

  always_comb begin
    case (head.op)
      lsb_pkg::lh, lsb_pkg::lhu, lsb_pkg::sh: misaligned = head.addr[0];
      lsb_pkg::lw, lsb_pkg::sw:               misaligned = |head.addr[1:0];
      default:                                misaligned = 1'b0;
    endcase
  end

  // queue frees the head on the ready edge
  assign head_pop = state != lsb_pkg::idle && mem_rsp.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= lsb_pkg::idle;
      mem_req.valid     <= 1'b0;
      load_result.valid <= 1'b0;
    end else begin
      load_result.valid <= 1'b0;
      case (state)
        lsb_pkg::idle: begin
          if (head_ready) begin
            mem_req.valid <= 1'b1;
            mem_req.write <= is_store;
            mem_req.addr  <= {head.addr[lsb_pkg::xlen-1:2], 2'b00};
            mem_req.wdata <= head.data << lane_shift;
            mem_req.wstrb <= is_store ? wstrb : 4'b0000;
            state         <= is_store ? lsb_pkg::wait_write : lsb_pkg::wait_read;
          end
        end
        lsb_pkg::wait_read: begin
          if (mem_rsp.ready) begin
            mem_req.valid      <= 1'b0;
            load_result.valid  <= 1'b1;
            load_result.rob_id <= head.rob_id;
            load_result.value  <= load_value;
            state              <= lsb_pkg::idle;
          end
        end
        lsb_pkg::wait_write: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            state         <= lsb_pkg::idle;
          end
        end
        default: state <= lsb_pkg::idle;
      endcase
    end
  end

  // the head that formed the request must stay put until ready
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
      mem_req.valid && !mem_rsp.ready |=> $stable(mem_req) && $stable(head)
  );

  a_no_ready_in_idle: assert property (
    @(posedge clk) disable iff (rst) state == lsb_pkg::idle |-> !mem_rsp.ready
  );

  a_aligned: assert property (
    @(posedge clk) disable iff (rst) head_ready |-> !misaligned
  );

endmodule

/* source/load_store_buffer.sv */
module load_store_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  lsb_pkg::issue_t       issue,
  input  lsb_pkg::cdb_t         cdb,
  input  logic                  commit_valid,
  input  lsb_pkg::rob_id_t      commit_id,
  input  lsb_pkg::mem_rsp_t     mem_rsp,
  output lsb_pkg::mem_req_t     mem_req,
  output lsb_pkg::load_result_t load_result,
  output logic                  full
);

  // retiring entry between queue and sequencer
  lsb_pkg::head_t head;
  logic           head_ready;
  logic           head_pop;

  lsb_entry_queue lsb_entry_queue_inst (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .cdb          (cdb),
    .commit_valid (commit_valid),
    .commit_id    (commit_id),
    .head_pop     (head_pop),
    .head         (head),
    .head_ready   (head_ready),
    .full         (full)
  );

  lsb_mem_sequencer lsb_mem_sequencer_inst (
    .clk         (clk),
    .rst         (rst),
    .head        (head),
    .head_ready  (head_ready),
    .mem_rsp     (mem_rsp),
    .head_pop    (head_pop),
    .mem_req     (mem_req),
    .load_result (load_result)
  );

endmodule

/* sim/lsb_tb.sv */
module lsb_tb;

  localparam int n_ops      = 80;
  localparam int clk_period = 40;
  localparam int mem_words  = 64;
  // first requests answered slowly so the queue fills up
  localparam int slow_reqs  = 12;
  localparam int slow_wait  = 12;

  logic clk, rst, issue_valid, commit_valid, full;
  lsb_pkg::issue_t       issue;
  lsb_pkg::cdb_t         cdb;
  lsb_pkg::rob_id_t      commit_id;
  lsb_pkg::mem_rsp_t     mem_rsp;
  lsb_pkg::mem_req_t     mem_req;
  lsb_pkg::load_result_t load_result;

  integer seed;
  lsb_pkg::ls_op_e      prog_op   [n_ops];
  lsb_pkg::word_t       prog_addr [n_ops];
  lsb_pkg::word_t       prog_data [n_ops];
  logic [11:0]          prog_imm  [n_ops];
  logic                 committed_flag [n_ops];
  lsb_pkg::word_t       mem [mem_words];
  lsb_pkg::word_t       shadow [mem_words];
  lsb_pkg::rob_id_t     exp_id [$];
  lsb_pkg::word_t       exp_val [$];
  int                   cq_due [$];
  int                   cq_idx [$];
  int                   next_op, req_ptr, outstanding, cyc, last_due, mem_wait, pj_cnt, pk_cnt;
  logic                 mem_active, full_seen;
  lsb_pkg::rob_id_t     pj_tag, pk_tag;
  lsb_pkg::word_t       pj_val, pk_val;

  load_store_buffer load_store_buffer_inst (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue), .cdb(cdb),
    .commit_valid(commit_valid), .commit_id(commit_id), .mem_rsp(mem_rsp),
    .mem_req(mem_req), .load_result(load_result), .full(full)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic mismatch(input string name, input lsb_pkg::word_t got, input lsb_pkg::word_t exp);
    fail_run($sformatf("mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                       $time, name, got, exp));
  endtask

  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  function automatic lsb_pkg::rob_id_t rob_of(input int i);
    rob_of = lsb_pkg::rob_id_t'((i % 15) + 1);
  endfunction

  function automatic lsb_pkg::word_t strobe_mask(input lsb_pkg::ls_op_e op, input logic [1:0] off);
    case (op)
      lsb_pkg::lb, lsb_pkg::lbu, lsb_pkg::sb: strobe_mask = 32'h0000_00ff << (8 * off);
      lsb_pkg::lh, lsb_pkg::lhu, lsb_pkg::sh: strobe_mask = 32'h0000_ffff << (8 * off);
      default:                                strobe_mask = 32'hffff_ffff;
    endcase
  endfunction

  // load value from the word, or merge a store into it
  function automatic lsb_pkg::word_t ref_access(input lsb_pkg::ls_op_e op,
      input lsb_pkg::word_t addr, input lsb_pkg::word_t data, inout lsb_pkg::word_t mem_word);
    lsb_pkg::word_t lane;
    lane = mem_word >> (8 * addr[1:0]);
    ref_access = '0;
    case (op)
      lsb_pkg::lb:  ref_access = {{24{lane[7]}}, lane[7:0]};
      lsb_pkg::lh:  ref_access = {{16{lane[15]}}, lane[15:0]};
      lsb_pkg::lbu: ref_access = {24'h0, lane[7:0]};
      lsb_pkg::lhu: ref_access = {16'h0, lane[15:0]};
      lsb_pkg::lw:  ref_access = mem_word;
      default: mem_word = (mem_word & ~strobe_mask(op, addr[1:0]))
                        | ((data << (8 * addr[1:0])) & strobe_mask(op, addr[1:0]));
    endcase
  endfunction

  task automatic build_program();
    int widx;
    logic [1:0] off;
    lsb_pkg::word_t w;
    lsb_pkg::word_t res;
    for (int i = 0; i < n_ops; i++) begin
      prog_op[i] = lsb_pkg::ls_op_e'(rand_below(8));
      widx = rand_below(mem_words);
      case (prog_op[i])
        lsb_pkg::lw, lsb_pkg::sw:               off = 2'd0;
        lsb_pkg::lh, lsb_pkg::lhu, lsb_pkg::sh: off = 2'(2 * rand_below(2));
        default:                                off = 2'(rand_below(4));
      endcase
      prog_addr[i] = {widx[29:0], off};
      prog_imm[i] = 12'(rand_below(4096));
      prog_data[i] = $random(seed);
      committed_flag[i] = 1'b0;
      w = shadow[widx];
      res = ref_access(prog_op[i], prog_addr[i], prog_data[i], w);
      shadow[widx] = w;
      if (prog_op[i] < lsb_pkg::sb) begin
        exp_id.push_back(rob_of(i));
        exp_val.push_back(res);
      end
    end
  endtask

  task automatic serve_memory();
    int widx;
    lsb_pkg::word_t mask;
    lsb_pkg::word_t strb_bytes;
    lsb_pkg::word_t exp_wdata;
    widx = mem_req.addr[7:2];
    mask = strobe_mask(prog_op[req_ptr], prog_addr[req_ptr][1:0]);
    // one byte lane per strobe bit
    strb_bytes = {{8{mem_req.wstrb[3]}}, {8{mem_req.wstrb[2]}}, {8{mem_req.wstrb[1]}},
                  {8{mem_req.wstrb[0]}}};
    exp_wdata = (prog_data[req_ptr] << (8 * prog_addr[req_ptr][1:0])) & mask;
    if (mem_rsp.ready) begin
      mem_rsp.ready = 1'b0;
    end else if (mem_req.valid) begin
      if (!mem_active) begin
        assert (req_ptr < n_ops) else fail_run("memory request after the program ended");
        assert (mem_req.addr == {prog_addr[req_ptr][31:2], 2'b00})
          else mismatch("mem_req.addr", mem_req.addr, {prog_addr[req_ptr][31:2], 2'b00});
        assert (mem_req.write == (prog_op[req_ptr] >= lsb_pkg::sb))
          else mismatch("mem_req.write", mem_req.write, prog_op[req_ptr] >= lsb_pkg::sb);
        if (mem_req.write) begin
          assert (committed_flag[req_ptr]) else fail_run("write request for an uncommitted store");
          assert (strb_bytes == mask) else mismatch("mem_req.wstrb", strb_bytes, mask);
          assert ((mem_req.wdata & mask) == exp_wdata)
            else mismatch("mem_req.wdata", mem_req.wdata & mask, exp_wdata);
        end
        mem_active = 1'b1;
        mem_wait   = req_ptr < slow_reqs ? slow_wait : rand_below(4);
      end
      if (mem_wait == 0) begin
        if (mem_req.write) begin
          mem[widx] = (mem[widx] & ~mask) | (mem_req.wdata & mask);
        end
        mem_rsp.rdata = mem[widx];
        mem_rsp.ready = 1'b1;
        mem_active    = 1'b0;
        req_ptr++;
      end else begin
        mem_wait--;
      end
    end
  endtask

  task automatic drive_inputs();
    int i;
    int due;
    i = next_op;
    issue_valid  = 1'b0;
    cdb          = '0;
    commit_valid = 1'b0;
    if (i < n_ops && !full && rand_below(4) != 0 && pj_cnt < 0 && pk_cnt < 0) begin
      issue_valid = 1'b1;
      issue = {prog_op[i], rob_of(i), 4'h0, 4'h0,
               prog_addr[i] - {{20{prog_imm[i][11]}}, prog_imm[i]}, prog_data[i], prog_imm[i]};
      // pending operands carry junk until the bus supplies them
      if (rand_below(4) == 0) begin
        pj_tag   = lsb_pkg::rob_id_t'(1 + rand_below(15));
        pj_val   = issue.vj;
        pj_cnt   = rand_below(4);
        issue.qj = pj_tag;
        issue.vj = $random(seed);
      end
      if (rand_below(4) == 0) begin
        pk_tag   = lsb_pkg::rob_id_t'(1 + (issue.qj != 0 ? pj_tag % 15 : rand_below(15)));
        pk_val   = issue.vk;
        pk_cnt   = issue.qj != 0 ? pj_cnt + 1 + rand_below(2) : rand_below(4);
        issue.qk = pk_tag;
        issue.vk = $random(seed);
      end
      if (prog_op[i] >= lsb_pkg::sb) begin
        due = cyc + 1 + rand_below(6);
        last_due = due > last_due ? due : last_due + 1;
        cq_due.push_back(last_due);
        cq_idx.push_back(i);
      end
      next_op++;
    end
    if (pj_cnt == 0) begin
      cdb = {1'b1, pj_tag, pj_val};
    end else if (pk_cnt == 0) begin
      cdb = {1'b1, pk_tag, pk_val};
    end
    pj_cnt = pj_cnt >= 0 ? pj_cnt - 1 : -1;
    pk_cnt = pk_cnt >= 0 ? pk_cnt - 1 : -1;
    if (cq_due.size() != 0 && cq_due[0] <= cyc) begin
      commit_valid = 1'b1;
      commit_id    = rob_of(cq_idx[0]);
      committed_flag[cq_idx[0]] = 1'b1;
      void'(cq_due.pop_front());
      void'(cq_idx.pop_front());
    end
  endtask

  initial begin
    seed = 97510;
    clk = 1'b0;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    cdb = '0;
    commit_valid = 1'b0;
    commit_id = '0;
    mem_rsp = '0;
    {next_op, req_ptr, outstanding, cyc, last_due, mem_wait} = '0;
    {mem_active, full_seen} = '0;
    pj_cnt = -1;
    pk_cnt = -1;
    for (int w = 0; w < mem_words; w++) begin
      mem[w] = $random(seed);
      shadow[w] = mem[w];
    end
    build_program();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!full && !mem_req.valid && !load_result.valid)
      else fail_run("outputs not low right after reset");
    while (next_op < n_ops || issue_valid || outstanding != 0 || exp_id.size() != 0) begin
      @(negedge clk);
      cyc++;
      outstanding += issue_valid - mem_rsp.ready;
      assert (full == (outstanding >= lsb_pkg::lsb_depth - 1))
        else mismatch("full", full, outstanding >= lsb_pkg::lsb_depth - 1);
      full_seen = full_seen | full;
      serve_memory();
      drive_inputs();
    end
    if (full_seen) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run("full never went high while memory was slow");
    end
  end

  // results in program order
  always @(negedge clk) begin
    if (!rst && load_result.valid) begin
      assert (exp_id.size() != 0) else fail_run("load result with no load outstanding");
      assert (load_result.rob_id == exp_id[0])
        else mismatch("load_result.rob_id", load_result.rob_id, exp_id[0]);
      assert (load_result.value == exp_val[0])
        else mismatch("load_result.value", load_result.value, exp_val[0]);
      void'(exp_id.pop_front());
      void'(exp_val.pop_front());
    end
  end

  initial begin
    #(n_ops * 20 * clk_period);
    fail_run("timeout: the program did not drain");
  end

endmodule

/* load_store_buffer.f */
source/lsb_pkg.sv
source/lsb_entry_queue.sv
source/lsb_mem_sequencer.sv
source/load_store_buffer.sv
sim/lsb_tb.sv

/* Bender.yml */
package:
  name: load_store_buffer

sources:
  - source/lsb_pkg.sv
  - source/lsb_entry_queue.sv
  - source/lsb_mem_sequencer.sv
  - source/load_store_buffer.sv
  - target: test
    files:
      - sim/lsb_tb.sv
